// File: src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,   // not a branch
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_op_e;

    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM_I,
        OP2_IMM_S
    } op2_sel_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

endpackage

// File: src/core_if.sv
`timescale 1ns/1ps

// decoded control for the current instruction
interface ctrl_if;
    import rv_pkg::*;

    alu_op_e                 alu_op;
    br_op_e                  br_op;
    op2_sel_e                op2_sel;
    wb_sel_e                 wb_sel;
    logic                    mem_wen;
    logic                    rf_wen;
    logic                    is_ecall;
    logic [REG_ADDR_W-1:0]   rs1_addr;
    logic [REG_ADDR_W-1:0]   rs2_addr;
    logic [REG_ADDR_W-1:0]   rd_addr;

    modport dec (output alu_op, br_op, op2_sel, wb_sel, mem_wen, rf_wen, is_ecall,
                        rs1_addr, rs2_addr, rd_addr);
    modport dp (input op2_sel, wb_sel, mem_wen, rf_wen, is_ecall,
                      rs1_addr, rs2_addr, rd_addr);
    modport ex (input alu_op, br_op);
endinterface

interface rf_if;
    import rv_pkg::*;

    logic [REG_ADDR_W-1:0]   rs1_addr;
    logic [REG_ADDR_W-1:0]   rs2_addr;
    logic [XLEN-1:0]         rs1_data;
    logic [XLEN-1:0]         rs2_data;
    logic                    wen;
    logic [REG_ADDR_W-1:0]   waddr;
    logic [XLEN-1:0]         wdata;

    modport core (output rs1_addr, rs2_addr, wen, waddr, wdata, input rs1_data, rs2_data);
    modport rf (input rs1_addr, rs2_addr, wen, waddr, wdata, output rs1_data, rs2_data);
endinterface

// File: src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [rv_pkg::XLEN-1:0] inst_i,
    ctrl_if.dec                     ctrl
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // register fields sit at fixed positions for every format
    assign ctrl.rs1_addr = inst_i[19:15];
    assign ctrl.rs2_addr = inst_i[24:20];
    assign ctrl.rd_addr  = inst_i[11:7];

    always_comb begin
        // defaults leave an unknown word harmless
        ctrl.alu_op   = ALU_ADD;
        ctrl.br_op    = BR_NONE;
        ctrl.op2_sel  = OP2_RS2;
        ctrl.wb_sel   = WB_ALU;
        ctrl.mem_wen  = 1'b0;
        ctrl.rf_wen   = 1'b0;
        ctrl.is_ecall = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin   // lw only
                    ctrl.op2_sel = OP2_IMM_I;
                    ctrl.wb_sel  = WB_MEM;
                    ctrl.rf_wen  = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin   // sw only
                    ctrl.op2_sel = OP2_IMM_S;
                    ctrl.mem_wen = 1'b1;
                end
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    ctrl.rf_wen = 1'b1;
                    case (funct3)
                        3'b000:  ctrl.alu_op = ALU_ADD;
                        3'b001:  ctrl.alu_op = ALU_SLL;
                        3'b010:  ctrl.alu_op = ALU_SLT;
                        3'b011:  ctrl.alu_op = ALU_SLTU;
                        3'b100:  ctrl.alu_op = ALU_XOR;
                        3'b101:  ctrl.alu_op = ALU_SRL;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        default: ctrl.alu_op = ALU_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) begin
                        ctrl.alu_op = ALU_SUB;
                        ctrl.rf_wen = 1'b1;
                    end else if (funct3 == 3'b101) begin
                        ctrl.alu_op = ALU_SRA;
                        ctrl.rf_wen = 1'b1;
                    end
                end
            end
            OPC_OP_IMM: begin
                ctrl.op2_sel = OP2_IMM_I;
                ctrl.rf_wen  = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = ALU_ADD;
                    3'b010: ctrl.alu_op = ALU_SLT;
                    3'b011: ctrl.alu_op = ALU_SLTU;
                    3'b100: ctrl.alu_op = ALU_XOR;
                    3'b110: ctrl.alu_op = ALU_OR;
                    3'b111: ctrl.alu_op = ALU_AND;
                    3'b001: begin
                        ctrl.alu_op = ALU_SLL;
                        ctrl.rf_wen = (funct7 == 7'b0000000);
                    end
                    default: begin   // srli / srai
                        ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        ctrl.rf_wen = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  ctrl.br_op = BR_EQ;
                    3'b001:  ctrl.br_op = BR_NE;
                    3'b100:  ctrl.br_op = BR_LT;
                    3'b101:  ctrl.br_op = BR_GE;
                    3'b110:  ctrl.br_op = BR_LTU;
                    3'b111:  ctrl.br_op = BR_GEU;
                    default: ctrl.br_op = BR_NONE;
                endcase
            end
            OPC_SYSTEM: begin
                ctrl.is_ecall = (inst_i[31:7] == '0);
            end
            default: ;
        endcase
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic clk,
    input  logic rst_n,
    rf_if.rf     rf
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wen && (rf.waddr != '0)) begin   // x0 stays zero
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // async read ports
    assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
    assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    ctrl_if.ex                      ctrl,
    input  logic [rv_pkg::XLEN-1:0] op1_i,
    input  logic [rv_pkg::XLEN-1:0] op2_i,
    output logic [rv_pkg::XLEN-1:0] result_o,
    output logic                    br_taken_o
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = op2_i[4:0];
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  result_o = op1_i + op2_i;
            ALU_SUB:  result_o = op1_i - op2_i;
            ALU_AND:  result_o = op1_i & op2_i;
            ALU_OR:   result_o = op1_i | op2_i;
            ALU_XOR:  result_o = op1_i ^ op2_i;
            ALU_SLL:  result_o = op1_i << shamt;
            ALU_SRL:  result_o = op1_i >> shamt;
            ALU_SRA:  result_o = XLEN'($signed(op1_i) >>> shamt);
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            default:  result_o = '0;
        endcase
    end

    // branch compare shares the less-than logic
    always_comb begin
        case (ctrl.br_op)
            BR_EQ:   br_taken_o = (op1_i == op2_i);
            BR_NE:   br_taken_o = (op1_i != op2_i);
            BR_LT:   br_taken_o = lt_s;
            BR_GE:   br_taken_o = !lt_s;
            BR_LTU:  br_taken_o = lt_u;
            BR_GEU:  br_taken_o = !lt_u;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] imem_data_i,
    output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
    output logic                    dmem_wen_o,
    output logic                    exit_o
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic            halt_q;
    logic            halt;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] alu_result;
    logic            br_taken;

    ctrl_if ctrl ();
    rf_if   rf ();

    inst_decoder i_inst_decoder (
        .inst_i (imem_data_i),
        .ctrl   (ctrl)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf)
    );

    alu i_alu (
        .ctrl       (ctrl),
        .op1_i      (rf.rs1_data),
        .op2_i      (op2),
        .result_o   (alu_result),
        .br_taken_o (br_taken)
    );

    // sign-extended immediates
    assign imm_i = {{(XLEN-12){imem_data_i[31]}}, imem_data_i[31:20]};
    assign imm_s = {{(XLEN-12){imem_data_i[31]}}, imem_data_i[31:25], imem_data_i[11:7]};
    assign imm_b = {{(XLEN-13){imem_data_i[31]}}, imem_data_i[31], imem_data_i[7],
                    imem_data_i[30:25], imem_data_i[11:8], 1'b0};

    always_comb begin
        case (ctrl.op2_sel)
            OP2_IMM_I: op2 = imm_i;
            OP2_IMM_S: op2 = imm_s;
            default:   op2 = rf.rs2_data;
        endcase
    end

    assign rf.rs1_addr = ctrl.rs1_addr;
    assign rf.rs2_addr = ctrl.rs2_addr;

    // ecall halts in the cycle it is fetched
    assign halt = halt_q || ctrl.is_ecall;

    assign rf.wen   = ctrl.rf_wen && !halt;
    assign rf.waddr = ctrl.rd_addr;
    assign rf.wdata = (ctrl.wb_sel == WB_MEM) ? dmem_rdata_i : alu_result;

    assign pc_next = br_taken ? pc_q + imm_b : pc_q + XLEN'(4);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q   <= '0;
            halt_q <= 1'b0;
        end else begin
            if (ctrl.is_ecall) begin
                halt_q <= 1'b1;   // sticky until reset
            end
            if (!halt) begin
                pc_q <= pc_next;
            end
        end
    end

    assign imem_addr_o  = pc_q;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rf.rs2_data;
    assign dmem_wen_o   = ctrl.mem_wen && !halt && rst_n;
    assign exit_o       = halt && rst_n;   // held low through reset

endmodule

// File: testbench/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] imem_addr_i,
    input logic        dmem_wen_i,
    input logic        exit_i
);

    a_no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_wen_i)
        else $error("store enabled during reset");

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr_i[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    // frozen core after ecall
    a_halt_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        exit_i |=> $stable(imem_addr_i) && !dmem_wen_i)
        else $error("core moved or stored after exit");

    a_exit_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        exit_i |=> exit_i)
        else $error("exit dropped before reset");

endmodule

bind rv_core rv_core_assertions i_rv_core_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_addr_i (imem_addr_o),
    .dmem_wen_i  (dmem_wen_o),
    .exit_i      (exit_o)
);

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int MAX_CYCLES = 2000;   // six programs of <= 40 instructions plus reset

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr, imem_data, dmem_addr, dmem_rdata, dmem_wdata;
    logic        dmem_wen, exit_flag;
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    int          n_inst;
    int          cycles;

    rv_core i_rv_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_rdata_i (dmem_rdata),
        .dmem_wdata_o (dmem_wdata),
        .dmem_wen_o   (dmem_wen),
        .exit_o       (exit_flag)
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_wen) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: core did not reach ecall within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $fatal(1, "simulation timeout");
        end
    end

    function automatic logic [31:0] r_insn(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] i_insn(int imm, int rs1, int f3, int rd, opcode_e opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_insn(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_insn(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] ecall_insn();
        return {25'b0, OPC_SYSTEM};
    endfunction

    function automatic logic [31:0] sext12(int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    function automatic logic [31:0] fill_word(int i);
        return 32'hc0de_0000 | i;
    endfunction

    task automatic check(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    task automatic emit(logic [31:0] word);
        imem[n_inst] = word;
        n_inst++;
    endtask

    // reset held while both memories get refilled
    task automatic begin_prog();
        rst_n = 1'b0;
        n_inst = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = i_insn(i, 0, 0, 0, OPC_OP_IMM);   // addi x0 nop
            dmem[i] = fill_word(i);
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic release_reset();
        @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic wait_exit();
        do begin
            @(posedge clk);
            #1;
        end while (!exit_flag);
    endtask

    task automatic reset_state();
        begin_prog();
        emit(s_insn(0, 0, 0));   // sw x0, 0(x0)
        emit(ecall_insn());
        #1;
        check("reset pc", 32'h0, imem_addr);
        check("reset exit", 32'h0, 32'(exit_flag));
        check("reset store enable", 32'h0, 32'(dmem_wen));
        release_reset();
        check("post-reset pc", 32'h0, imem_addr);
        check("post-reset exit", 32'h0, 32'(exit_flag));
        wait_exit();
        check("store x0", 32'h0, dmem[0]);
    endtask

    task automatic reg_alu_ops();
        int          f3s [10] = '{0, 0, 7, 6, 4, 1, 5, 5, 2, 3};
        int          f7s [10] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};
        logic [31:0] a, b, exp;
        begin_prog();
        a = $urandom() | 32'h8000_0000;   // negative
        b = $urandom() & 32'h7fff_ffff;   // positive
        dmem[0] = a;
        dmem[1] = b;
        emit(i_insn(0, 0, 2, 1, OPC_LOAD));
        emit(i_insn(4, 0, 2, 2, OPC_LOAD));
        emit(i_insn(-5, 0, 0, 13, OPC_OP_IMM));
        for (int k = 0; k < 10; k++) begin
            emit(r_insn(f7s[k], 2, 1, f3s[k], 3));
            emit(s_insn(64 + 4 * k, 3, 0));
        end
        emit(r_insn(0, 13, 1, 0, 4));   // add with addi operand
        emit(s_insn(128, 4, 0));
        emit(ecall_insn());
        release_reset();
        wait_exit();
        for (int k = 0; k < 10; k++) begin
            case (k)
                0: exp = a + b;
                1: exp = a - b;
                2: exp = a & b;
                3: exp = a | b;
                4: exp = a ^ b;
                5: exp = a << b[4:0];
                6: exp = a >> b[4:0];
                7: exp = $signed(a) >>> b[4:0];
                8: exp = ($signed(a) < $signed(b)) ? 1 : 0;
                default: exp = (a < b) ? 1 : 0;
            endcase
            check($sformatf("reg op %0d", k), exp, dmem[16 + k]);
        end
        check("add addi operand", a - 5, dmem[32]);
    endtask

    task automatic imm_alu_ops();
        int          f3s [9]  = '{0, 7, 6, 4, 1, 5, 5, 2, 3};
        int          imms [9] = '{-7, -256, 'h123, -1, 7, 9, 'h409, -3, -3};
        logic [31:0] a, exp, imm;
        begin_prog();
        a = $urandom() | 32'h8000_0000;
        dmem[0] = a;
        emit(i_insn(0, 0, 2, 1, OPC_LOAD));
        for (int k = 0; k < 9; k++) begin
            emit(i_insn(imms[k], 1, f3s[k], 3, OPC_OP_IMM));
            emit(s_insn(64 + 4 * k, 3, 0));
        end
        emit(ecall_insn());
        release_reset();
        wait_exit();
        for (int k = 0; k < 9; k++) begin
            imm = sext12(imms[k]);
            case (k)
                0: exp = a + imm;
                1: exp = a & imm;
                2: exp = a | imm;
                3: exp = a ^ imm;
                4: exp = a << imm[4:0];
                5: exp = a >> imm[4:0];
                6: exp = $signed(a) >>> imm[4:0];
                7: exp = ($signed(a) < $signed(imm)) ? 1 : 0;
                default: exp = (a < imm) ? 1 : 0;
            endcase
            check($sformatf("imm op %0d", k), exp, dmem[16 + k]);
        end
    endtask

    task automatic mem_round_trip();
        logic [31:0] v;
        begin_prog();
        v = $urandom();
        dmem[10] = v;
        emit(i_insn(128, 0, 0, 5, OPC_OP_IMM));   // base 0x80
        emit(i_insn(-88, 5, 2, 6, OPC_LOAD));
        emit(i_insn('h55, 6, 0, 6, OPC_OP_IMM));
        emit(s_insn(-4, 6, 5));
        emit(i_insn(-88, 5, 2, 0, OPC_LOAD));     // load into x0
        emit(s_insn(-8, 0, 5));
        emit(ecall_insn());
        release_reset();
        wait_exit();
        check("mem round trip", v + 32'h55, dmem[31]);
        check("x0 after load", 32'h0, dmem[30]);
        check("source word", v, dmem[10]);
    endtask

    task automatic branch_paths();
        int          f3s [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
        int          ra [12]  = '{1, 1, 1, 1, 1, 2, 2, 1, 2, 1, 1, 2};
        int          rb [12]  = '{1, 2, 2, 1, 2, 1, 1, 2, 1, 2, 2, 1};
        logic [31:0] x [3];
        logic [31:0] a, b;
        logic        taken;
        begin_prog();
        x[1] = 32'hffff_fffe;
        x[2] = 32'd3;
        emit(i_insn(-2, 0, 0, 1, OPC_OP_IMM));
        emit(i_insn(3, 0, 0, 2, OPC_OP_IMM));
        emit(i_insn(1, 0, 0, 3, OPC_OP_IMM));
        for (int k = 0; k < 12; k++) begin
            emit(b_insn(8, rb[k], ra[k], f3s[k]));
            emit(s_insn(256 + 4 * k, 3, 0));   // marker in the skipped slot
        end
        emit(ecall_insn());
        release_reset();
        wait_exit();
        for (int k = 0; k < 12; k++) begin
            a = x[ra[k]];
            b = x[rb[k]];
            case (f3s[k])
                0: taken = (a == b);
                1: taken = (a != b);
                4: taken = $signed(a) < $signed(b);
                5: taken = $signed(a) >= $signed(b);
                6: taken = a < b;
                default: taken = a >= b;
            endcase
            check($sformatf("branch %0d", k), taken ? fill_word(64 + k) : 32'h1, dmem[64 + k]);
        end
    endtask

    task automatic halt_freeze();
        begin_prog();
        emit(i_insn(7, 0, 0, 3, OPC_OP_IMM));
        emit(s_insn(256, 3, 0));
        emit(ecall_insn());
        emit(s_insn(260, 3, 0));
        emit(s_insn(264, 3, 0));
        release_reset();
        wait_exit();
        repeat (4) @(posedge clk);
        #1;
        check("halt exit", 32'h1, 32'(exit_flag));
        check("halt pc", 32'h8, imem_addr);
        check("store before ecall", 32'h7, dmem[64]);
        check("store after ecall", fill_word(65), dmem[65]);
        check("second store after ecall", fill_word(66), dmem[66]);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cycles = 0;
        n_inst = 0;
        void'($urandom(32'h441e));
        reset_state();
        reg_alu_ops();
        imm_alu_ops();
        mem_round_trip();
        branch_paths();
        halt_freeze();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: flist.f
src/rv_pkg.sv
src/core_if.sv
src/inst_decoder.sv
src/reg_file.sv
src/alu.sv
src/rv_core.sv
testbench/rv_core_assertions.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f flist.f --top-module tb_rv_core -o sim_rv_core

./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    exit 1
fi
